/* files.f */
+incdir+.
blit_pkg.sv
blit_if.sv
blit_regs.sv
blit_sequencer.sv
blit_datapath.sv
blitter.sv
tb_blitter.sv

/* run.sh */
#!/bin/sh
verilator --binary -f files.f --top-module tb_blitter -o tb_blitter_sim \
   && ./obj_dir/tb_blitter_sim | tee /dev/stderr \
      | grep -q "Simulation completed successfully" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

/* blit_model.svh */
`ifndef BLIT_MODEL_SVH
`define BLIT_MODEL_SVH

// ------------------------------
// reference model of one blit
// ------------------------------
// state is loaded by the stimulus before the start write
logic [15:0] exp_mem [4096];
logic [15:0] ht_tab [16];
logic [15:0] em1;
logic [15:0] em2;
logic [15:0] em3;
logic [1:0]  hop_v;
logic [3:0]  op_v;
// word addresses and signed word steps
int          src_a;
int          dst_a;
int          src_dx;
int          src_dy;
int          dst_dx;
int          dst_dy;
int          x_cnt;
int          y_cnt;
int          line_no;
int          skew_v;
int          exp_reads;
int          exp_writes;

// truth table lookup, index is {not src, not dst}
function automatic logic [15:0] apply_op(input logic [3:0] op, input logic [15:0] s,
                                         input logic [15:0] d);
   logic [15:0] r;
   for (int i = 0; i < 16; i++)
      r[i] = op[{~s[i], ~d[i]}];
   return r;
endfunction

task automatic model_blit();
   logic [31:0] sbuf;
   logic [15:0] dbuf;
   logic [15:0] src16;
   logic [15:0] ht_src;
   logic [15:0] mask;
   logic [15:0] rd;
   logic        first;
   logic        last;
   logic        need_s;
   logic        need_d;
   // buffer starts empty for every blit
   sbuf = '0;
   dbuf = '0;
   exp_reads = 0;
   exp_writes = 0;
   // source only matters to ops with a src term and hops 2 and 3
   need_s = !(op_v inside {4'd0, 4'd5, 4'd10, 4'd15}) && (hop_v >= 2'd2);
   for (int y = 0; y < y_cnt; y++) begin
      for (int x = x_cnt; x >= 1; x--) begin
         first = (x == x_cnt);
         last  = (x == 1);
         mask  = first ? em1 : (last ? em3 : em2);
         // old dst needed by the op or by a partial mask
         need_d = !(op_v inside {4'd0, 4'd3, 4'd12, 4'd15}) || (mask != 16'hffff);
         if (need_s) begin
            rd = exp_mem[src_a[11:0]];
            sbuf = (src_dx < 0) ? {rd, sbuf[31:16]} : {sbuf[15:0], rd};
            src_a += last ? src_dy : src_dx;
            exp_reads++;
         end
         if (need_d) begin
            dbuf = exp_mem[dst_a[11:0]];
            exp_reads++;
         end
         src16 = 16'(sbuf >> skew_v);
         case (hop_v)
            2'd0:    ht_src = 16'hffff;
            2'd1:    ht_src = ht_tab[line_no[3:0]];
            2'd2:    ht_src = src16;
            default: ht_src = ht_tab[line_no[3:0]] & src16;
         endcase
         exp_mem[dst_a[11:0]] = (apply_op(op_v, ht_src, dbuf) & mask) | (dbuf & ~mask);
         exp_writes++;
         dst_a += last ? dst_dy : dst_dx;
      end
      // halftone line runs against the dst y direction
      line_no = (dst_dy < 0) ? (line_no + 1) % 16 : (line_no + 15) % 16;
   end
endtask

`endif

/* tb_blitter.sv */
`timescale 1ns/1ps

module tb_blitter;
   import blit_pkg::*;

   logic        clk;
   logic        reset;
   logic        sel;
   logic        we;
   logic [4:0]  addr;
   logic [15:0] wdata;
   logic [15:0] rdata;
   logic        irq;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [22:0] wb_adr;
   logic [15:0] wb_dat_o;
   logic [15:0] wb_dat_i;
   logic        wb_ack;

   // wishbone side memory and its traffic counts
   logic [15:0] mem [4096];
   int          read_count;
   int          write_count;
   logic [31:0] stim_seed;
   logic [31:0] wait_seed;
   // grows by the expected transfers of every blit
   int          cycle_budget = 4000;

   `include "blit_model.svh"

   blitter dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ------------------------------
   // helpers
   // ------------------------------
   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int rand_range(input int lo, input int hi);
      stim_seed = lcg(stim_seed);
      return lo + int'(stim_seed[31:8] % 24'(hi - lo + 1));
   endfunction

   function automatic logic [15:0] rand_word();
      return 16'(rand_range(0, 65535));
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, got, exp);
         $display("Simulation failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // one cpu write, inputs move 1 ns after the edge
   task automatic reg_write(input logic [4:0] a, input logic [15:0] d);
      @(posedge clk);
      #1;
      sel   = 1'b1;
      we    = 1'b1;
      addr  = a;
      wdata = d;
      @(posedge clk);
      #1;
      sel = 1'b0;
      we  = 1'b0;
   endtask

   // rdata is combinational, sampled mid cycle
   task automatic reg_read(input logic [4:0] a, output logic [15:0] d);
      @(posedge clk);
      #1;
      sel  = 1'b1;
      we   = 1'b0;
      addr = a;
      #1;
      d   = rdata;
      sel = 1'b0;
   endtask

   // bits that survive a write and read back
   function automatic logic [15:0] readback_mask(input logic [4:0] a);
      case (a)
         reg_src_x_inc, reg_src_y_inc, reg_dst_x_inc, reg_dst_y_inc,
         reg_src_lo, reg_dst_lo: return 16'hfffe;
         reg_src_hi, reg_dst_hi: return 16'h00ff;
         reg_op:                 return 16'h030f;
         reg_ctrl:               return 16'h0f0f;
         default:                return 16'hffff;
      endcase
   endfunction

   // ------------------------------
   // wishbone memory, 0 to 3 wait cycles
   // ------------------------------
   initial begin : wb_memory
      int waits;
      wb_ack      = 1'b0;
      wb_dat_i    = '0;
      read_count  = 0;
      write_count = 0;
      wait_seed   = 32'hd914;
      for (int i = 0; i < 4096; i++)
         mem[i[11:0]] = 16'(i * 40503) ^ 16'(i >> 5);
      forever begin
         @(posedge clk);
         #1;
         wb_ack = 1'b0;
         if (wb_cyc && wb_stb) begin
            wait_seed = lcg(wait_seed);
            waits = int'(wait_seed[31:30]);
            repeat (waits) begin
               @(posedge clk);
               #1;
            end
            check("wishbone address inside memory", 32'(wb_adr[22:12]), 0);
            if (wb_we) begin
               mem[wb_adr[11:0]] = wb_dat_o;
               write_count++;
            end else begin
               wb_dat_i = mem[wb_adr[11:0]];
               read_count++;
            end
            wb_ack = 1'b1;
         end
      end
   end

   initial begin : watchdog
      int cycles_run;
      cycles_run = 0;
      while (cycles_run <= cycle_budget) begin
         @(posedge clk);
         cycles_run++;
      end
      $display("timeout: the run took more than %0d clock cycles", cycle_budget);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

   // ------------------------------
   // tests
   // ------------------------------
   task automatic register_test();
      logic [15:0] written [32];
      logic [15:0] got;
      for (int a = 0; a < 31; a++) begin
         written[a[4:0]] = rand_word();
         // keep the start bit clear
         if (5'(a) == reg_ctrl)
            written[a[4:0]][15] = 1'b0;
         reg_write(5'(a), written[a[4:0]]);
      end
      for (int a = 0; a < 31; a++) begin
         reg_read(5'(a), got);
         check($sformatf("register %0h readback", a), 32'(got),
               32'(written[a[4:0]] & readback_mask(5'(a))));
      end
   endtask

   task automatic start_without_rows();
      reg_write(reg_y_count, 16'h0000);
      reg_write(reg_ctrl, 16'h8000);
      repeat (10) begin
         @(posedge clk);
         #1;
         check("irq after start with no rows", 32'(irq), 0);
         check("wb_cyc after start with no rows", 32'(wb_cyc), 0);
      end
   endtask

   task automatic random_blit(input int n);
      logic [15:0] ctrl_word;
      logic [15:0] got;
      logic [15:0] hi;
      int          r0;
      int          w0;
      for (int i = 0; i < 16; i++) begin
         ht_tab[i[3:0]] = rand_word();
         reg_write(5'(i), ht_tab[i[3:0]]);
      end
      src_dx  = rand_range(-3, 3);
      src_dy  = rand_range(-40, 40);
      dst_dx  = rand_range(-3, 3);
      dst_dy  = rand_range(-40, 40);
      // start well inside memory, steps never reach the edges
      src_a   = rand_range(512, 3583);
      dst_a   = rand_range(512, 3583);
      x_cnt   = rand_range(1, 6);
      y_cnt   = rand_range(1, 4);
      em1     = (rand_range(0, 2) == 0) ? 16'hffff : rand_word();
      em2     = (rand_range(0, 2) == 0) ? 16'hffff : rand_word();
      em3     = (rand_range(0, 2) == 0) ? 16'hffff : rand_word();
      op_v    = 4'(rand_range(0, 15));
      hop_v   = 2'(rand_range(0, 3));
      skew_v  = rand_range(0, 15);
      line_no = rand_range(0, 15);
      reg_write(reg_src_x_inc, 16'(src_dx * 2));
      reg_write(reg_src_y_inc, 16'(src_dy * 2));
      reg_write(reg_src_hi, 16'(src_a >> 15));
      reg_write(reg_src_lo, 16'(src_a * 2));
      reg_write(reg_dst_x_inc, 16'(dst_dx * 2));
      reg_write(reg_dst_y_inc, 16'(dst_dy * 2));
      reg_write(reg_dst_hi, 16'(dst_a >> 15));
      reg_write(reg_dst_lo, 16'(dst_a * 2));
      reg_write(reg_endmask1, em1);
      reg_write(reg_endmask2, em2);
      reg_write(reg_endmask3, em3);
      reg_write(reg_x_count, 16'(x_cnt));
      reg_write(reg_y_count, 16'(y_cnt));
      reg_write(reg_op, {6'd0, hop_v, 4'd0, op_v});
      ctrl_word = {1'b1, 3'd0, 4'(line_no), 4'd0, 4'(skew_v)};
      model_blit();
      cycle_budget += 200 * (exp_reads + exp_writes) + 200;
      r0 = read_count;
      w0 = write_count;
      reg_write(reg_ctrl, ctrl_word);
      check("irq after start", 32'(irq), 1);
      // counter and line number writes land while busy and must be ignored
      if (n % 2 == 1) begin
         case (n % 3)
            0:       reg_write(reg_x_count, rand_word());
            1:       reg_write(reg_y_count, rand_word());
            default: reg_write(reg_ctrl, rand_word());
         endcase
      end
      while (irq) begin
         @(posedge clk);
         #1;
      end
      check("wb_cyc after irq falls", 32'(wb_cyc), 0);
      check("wishbone reads", 32'(read_count - r0), 32'(exp_reads));
      check("wishbone writes", 32'(write_count - w0), 32'(exp_writes));
      for (int i = 0; i < 4096; i++) begin
         if (mem[i[11:0]] !== exp_mem[i[11:0]])
            check($sformatf("memory word %0h", i), 32'(mem[i[11:0]]), 32'(exp_mem[i[11:0]]));
      end
      reg_read(reg_y_count, got);
      check("y_count after blit", 32'(got), 0);
      reg_read(reg_x_count, got);
      check("x_count after blit", 32'(got), 32'(x_cnt));
      reg_read(reg_src_hi, hi);
      reg_read(reg_src_lo, got);
      check("source address after blit", 32'({hi[7:0], got[15:1]}), 32'(23'(src_a)));
      reg_read(reg_dst_hi, hi);
      reg_read(reg_dst_lo, got);
      check("destination address after blit", 32'({hi[7:0], got[15:1]}), 32'(23'(dst_a)));
      reg_read(reg_ctrl, got);
      check("line number and skew after blit", 32'(got),
            32'({4'h0, 4'(line_no), 4'h0, 4'(skew_v)}));
   endtask

   initial begin : stimulus
      stim_seed = 32'hd914;
      reset = 1'b1;
      sel   = 1'b0;
      we    = 1'b0;
      addr  = '0;
      wdata = '0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      check("irq after reset", 32'(irq), 0);
      check("wb_cyc after reset", 32'(wb_cyc), 0);
      check("wb_stb after reset", 32'(wb_stb), 0);
      register_test();
      start_without_rows();
      for (int i = 0; i < 4096; i++)
         exp_mem[i[11:0]] = mem[i[11:0]];
      for (int n = 0; n < 30; n++)
         random_blit(n);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* blitter.sv */
`timescale 1ns/1ps

module blitter (
   input  logic                            clk,
   input  logic                            reset,
   // cpu register port
   input  logic                            sel,
   input  logic                            we,
   input  logic [blit_pkg::reg_addr_w-1:0] addr,
   input  logic [blit_pkg::word_w-1:0]     wdata,
   output logic [blit_pkg::word_w-1:0]     rdata,
   output logic                            irq,
   // wishbone master
   output logic                            wb_cyc,
   output logic                            wb_stb,
   output logic                            wb_we,
   output logic [blit_pkg::adr_w-1:0]      wb_adr,
   output logic [blit_pkg::word_w-1:0]     wb_dat_o,
   input  logic [blit_pkg::word_w-1:0]     wb_dat_i,
   input  logic                            wb_ack
);

   blit_cfg_if  cfg_bus ();
   blit_step_if step_bus ();

   // ------------------------------
   // decode, execute, result
   // ------------------------------
   blit_regs regs0 (
      .clk   (clk),
      .reset (reset),
      .sel   (sel),
      .we    (we),
      .addr  (addr),
      .wdata (wdata),
      .rdata (rdata),
      .cfg   (cfg_bus)
   );

   blit_sequencer seq0 (
      .clk      (clk),
      .reset    (reset),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .cfg      (cfg_bus),
      .step     (step_bus)
   );

   blit_datapath dp0 (
      .cfg   (cfg_bus),
      .step  (step_bus),
      .clk   (clk),
      .reset (reset)
   );

   assign wb_dat_o = step_bus.wr_data;
   // interrupt line mirrors busy
   assign irq      = cfg_bus.busy;

endmodule

/* blit_datapath.sv */
`timescale 1ns/1ps

module blit_datapath (
   blit_cfg_if.dp  cfg,
   blit_step_if.dp step,
   input  logic    clk,
   input  logic    reset
);
   import blit_pkg::*;

   logic [2*word_w-1:0] src_buf;
   logic [2*word_w-1:0] src_shifted;
   logic [word_w-1:0]   dst_buf;
   logic [word_w-1:0]   src_skewed;
   logic [word_w-1:0]   src_ht;
   logic [word_w-1:0]   result;
   logic [word_w-1:0]   mask;

   // ------------------------------
   // source and destination buffers
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset || step.clear) begin
         src_buf <= '0;
      end else if (step.src_load) begin
         // shift direction follows the sign of the x step
         if (cfg.src_x_inc[word_w-1])
            src_buf <= {step.rd_data, src_buf[2*word_w-1:word_w]};
         else
            src_buf <= {src_buf[word_w-1:0], step.rd_data};
      end
   end

   always_ff @(posedge clk) begin
      if (step.dst_load)
         dst_buf <= step.rd_data;
   end

   // ------------------------------
   // write word
   // ------------------------------
   // skew picks 16 bits out of the 32 bit window
   assign src_shifted = src_buf >> cfg.skew;
   assign src_skewed  = src_shifted[word_w-1:0];

   always_comb begin
      case (cfg.hop)
         hop_ones:     src_ht = '1;
         hop_halftone: src_ht = cfg.ht_line;
         hop_source:   src_ht = src_skewed;
         default:      src_ht = cfg.ht_line & src_skewed;
      endcase

      // src_ht against dst_buf
      case (cfg.op)
         op_zero:            result = '0;
         op_and:             result = src_ht & dst_buf;
         op_and_not_dst:     result = src_ht & ~dst_buf;
         op_src:             result = src_ht;
         op_not_src_and_dst: result = ~src_ht & dst_buf;
         op_dst:             result = dst_buf;
         op_xor:             result = src_ht ^ dst_buf;
         op_or:              result = src_ht | dst_buf;
         op_nor:             result = ~(src_ht | dst_buf);
         op_xnor:            result = ~(src_ht ^ dst_buf);
         op_not_dst:         result = ~dst_buf;
         op_src_or_not_dst:  result = src_ht | ~dst_buf;
         op_not_src:         result = ~src_ht;
         op_not_src_or_dst:  result = ~src_ht | dst_buf;
         op_nand:            result = ~(src_ht & dst_buf);
         default:            result = '1;
      endcase
   end

   // first wins over last on single-word rows
   assign mask = step.first ? cfg.endmask1 : (step.last ? cfg.endmask3 : cfg.endmask2);

   assign step.wr_data = (result & mask) | (dst_buf & ~mask);

endmodule

/* blit_sequencer.sv */
`timescale 1ns/1ps

module blit_sequencer (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [blit_pkg::word_w-1:0] wb_dat_i,
   input  logic                        wb_ack,
   output logic                        wb_cyc,
   output logic                        wb_stb,
   output logic                        wb_we,
   output logic [blit_pkg::adr_w-1:0]  wb_adr,
   blit_cfg_if.seq                     cfg,
   blit_step_if.seq                    step
);
   import blit_pkg::*;

   seq_state_e        state;
   seq_state_e        first_state;
   seq_state_e        after_src;
   logic              word_done;
   logic              first;
   logic              last;
   logic              need_src;
   logic              need_dst;
   logic              xfer_done;
   logic [word_w-1:0] mask;

   // ------------------------------
   // word position and read needs
   // ------------------------------
   assign first = cfg.x_count == cfg.x_count_latch;
   assign last  = cfg.x_count == 16'd1;

   // a single-word row uses endmask1
   assign mask = first ? cfg.endmask1 : (last ? cfg.endmask3 : cfg.endmask2);

   assign need_src = op_uses_src(cfg.op) && hop_uses_src(cfg.hop);
   // partial mask keeps old dst bits, so dst must be read
   assign need_dst = op_uses_dst(cfg.op) || (mask != 16'hffff);

   always_comb begin
      if (need_src)
         first_state = st_src_read;
      else if (need_dst)
         first_state = st_dst_read;
      else
         first_state = st_dst_write;
      after_src = need_dst ? st_dst_read : st_dst_write;
   end

   assign xfer_done = wb_stb && wb_ack;

   // ------------------------------
   // wishbone master fsm
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= st_idle;
         wb_cyc    <= 1'b0;
         wb_stb    <= 1'b0;
         word_done <= 1'b0;
      end else if (state == st_idle) begin
         // cyc and stb rise together, bus held until the blit is done
         if (cfg.busy) begin
            state     <= first_state;
            wb_cyc    <= 1'b1;
            wb_stb    <= 1'b1;
            word_done <= 1'b0;
         end
      end else if (xfer_done) begin
         // stb drops for one cycle after every ack
         wb_stb <= 1'b0;
         case (state)
            st_src_read: state <= after_src;
            st_dst_read: state <= st_dst_write;
            default:     word_done <= 1'b1;
         endcase
      end else if (!wb_stb) begin
         if (word_done) begin
            // counters have stepped, pick the next word or finish
            word_done <= 1'b0;
            if (cfg.y_count == '0) begin
               state  <= st_idle;
               wb_cyc <= 1'b0;
            end else begin
               state  <= first_state;
               wb_stb <= 1'b1;
            end
         end else begin
            wb_stb <= 1'b1;
         end
      end
   end

   // address and direction stay stable while stb is up
   assign wb_we  = wb_stb && (state == st_dst_write);
   assign wb_adr = (state == st_src_read) ? cfg.src_addr : cfg.dst_addr;

   // ------------------------------
   // strobes to regs and datapath
   // ------------------------------
   assign cfg.start_ack = (state == st_idle) && cfg.busy;
   assign cfg.src_step  = xfer_done && (state == st_src_read);
   assign cfg.dst_step  = xfer_done && (state == st_dst_write);
   assign cfg.row_end   = last;

   assign step.clear    = cfg.start_ack;
   assign step.src_load = cfg.src_step;
   assign step.dst_load = xfer_done && (state == st_dst_read);
   assign step.first    = first;
   assign step.last     = last;
   assign step.rd_data  = wb_dat_i;

endmodule

/* blit_regs.sv */
`timescale 1ns/1ps

module blit_regs (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             sel,
   input  logic                             we,
   input  logic [blit_pkg::reg_addr_w-1:0]  addr,
   input  logic [blit_pkg::word_w-1:0]      wdata,
   output logic [blit_pkg::word_w-1:0]      rdata,
   blit_cfg_if.regs                         cfg
);
   import blit_pkg::*;

   logic [word_w-1:0] ht_ram [ht_lines];
   logic [line_w-1:0] line_number;
   logic              cpu_wr;

   // signed word step, widened to the address
   function automatic logic [adr_w-1:0] sext(input logic [word_w-1:1] inc);
      return {{(adr_w-word_w+1){inc[word_w-1]}}, inc};
   endfunction

   // everything but the start bit is locked while busy
   assign cpu_wr      = sel && we && !cfg.busy;
   assign cfg.ht_line = ht_ram[line_number];

   // ------------------------------
   // cpu read, unused bits zero
   // ------------------------------
   always_comb begin
      rdata = '0;
      if (sel && !we) begin
         if (!addr[reg_addr_w-1])
            rdata = ht_ram[addr[line_w-1:0]];
         case (addr)
            reg_src_x_inc: rdata = {cfg.src_x_inc, 1'b0};
            reg_src_y_inc: rdata = {cfg.src_y_inc, 1'b0};
            reg_src_hi:    rdata = {8'h00, cfg.src_addr[adr_w-1:word_w-1]};
            reg_src_lo:    rdata = {cfg.src_addr[word_w-2:0], 1'b0};
            reg_endmask1:  rdata = cfg.endmask1;
            reg_endmask2:  rdata = cfg.endmask2;
            reg_endmask3:  rdata = cfg.endmask3;
            reg_dst_x_inc: rdata = {cfg.dst_x_inc, 1'b0};
            reg_dst_y_inc: rdata = {cfg.dst_y_inc, 1'b0};
            reg_dst_hi:    rdata = {8'h00, cfg.dst_addr[adr_w-1:word_w-1]};
            reg_dst_lo:    rdata = {cfg.dst_addr[word_w-2:0], 1'b0};
            reg_x_count:   rdata = cfg.x_count;
            reg_y_count:   rdata = cfg.y_count;
            reg_op:        rdata = {6'd0, cfg.hop, 4'd0, cfg.op};
            reg_ctrl:      rdata = {cfg.busy, 3'd0, line_number, 4'd0, cfg.skew};
            default: ;
         endcase
      end
   end

   // ------------------------------
   // counters, line number, busy
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         cfg.busy          <= 1'b0;
         cfg.x_count       <= '0;
         cfg.x_count_latch <= '0;
         cfg.y_count       <= '0;
         line_number       <= '0;
      end else begin
         if (cpu_wr) begin
            case (addr)
               reg_x_count: begin
                  cfg.x_count       <= wdata;
                  cfg.x_count_latch <= wdata;
               end
               reg_y_count: cfg.y_count <= wdata;
               reg_ctrl: begin
                  line_number <= wdata[11:8];
                  // start only with rows left to do
                  if (wdata[ctrl_busy_bit] && cfg.y_count != '0)
                     cfg.busy <= 1'b1;
               end
               default: ;
            endcase
         end
         // done once the last row is written
         if (cfg.busy && cfg.y_count == '0)
            cfg.busy <= 1'b0;
         if (cfg.dst_step) begin
            if (cfg.row_end) begin
               cfg.x_count <= cfg.x_count_latch;
               cfg.y_count <= cfg.y_count - 1'b1;
               // halftone walks against the vertical direction
               if (cfg.dst_y_inc[word_w-1])
                  line_number <= line_number + 1'b1;
               else
                  line_number <= line_number - 1'b1;
            end else begin
               cfg.x_count <= cfg.x_count - 1'b1;
            end
         end
      end
   end

   // ------------------------------
   // config, halftone ram, addresses
   // ------------------------------
   always_ff @(posedge clk) begin
      if (cpu_wr) begin
         if (!addr[reg_addr_w-1])
            ht_ram[addr[line_w-1:0]] <= wdata;
         case (addr)
            reg_src_x_inc: cfg.src_x_inc <= wdata[word_w-1:1];
            reg_src_y_inc: cfg.src_y_inc <= wdata[word_w-1:1];
            reg_src_hi:    cfg.src_addr[adr_w-1:word_w-1] <= wdata[7:0];
            reg_src_lo:    cfg.src_addr[word_w-2:0] <= wdata[word_w-1:1];
            reg_endmask1:  cfg.endmask1 <= wdata;
            reg_endmask2:  cfg.endmask2 <= wdata;
            reg_endmask3:  cfg.endmask3 <= wdata;
            reg_dst_x_inc: cfg.dst_x_inc <= wdata[word_w-1:1];
            reg_dst_y_inc: cfg.dst_y_inc <= wdata[word_w-1:1];
            reg_dst_hi:    cfg.dst_addr[adr_w-1:word_w-1] <= wdata[7:0];
            reg_dst_lo:    cfg.dst_addr[word_w-2:0] <= wdata[word_w-1:1];
            reg_op: begin
               cfg.hop <= hop_e'(wdata[9:8]);
               cfg.op  <= blit_op_e'(wdata[3:0]);
            end
            reg_ctrl:      cfg.skew <= wdata[skew_w-1:0];
            default: ;
         endcase
      end
      // x step inside a row, y step at its end
      if (cfg.src_step)
         cfg.src_addr <= cfg.src_addr + (cfg.row_end ? sext(cfg.src_y_inc) : sext(cfg.src_x_inc));
      if (cfg.dst_step)
         cfg.dst_addr <= cfg.dst_addr + (cfg.row_end ? sext(cfg.dst_y_inc) : sext(cfg.dst_x_inc));
   end

endmodule

/* blit_if.sv */
`timescale 1ns/1ps

// configuration from the register file, events back from the sequencer
interface blit_cfg_if;
   import blit_pkg::*;

   logic [word_w-1:0] ht_line;
   // increments are word steps, bit 0 of the byte value dropped
   logic [word_w-1:1] src_x_inc;
   logic [word_w-1:1] src_y_inc;
   logic [adr_w-1:0]  src_addr;
   logic [word_w-1:1] dst_x_inc;
   logic [word_w-1:1] dst_y_inc;
   logic [adr_w-1:0]  dst_addr;
   logic [word_w-1:0] endmask1;
   logic [word_w-1:0] endmask2;
   logic [word_w-1:0] endmask3;
   logic [word_w-1:0] x_count;
   logic [word_w-1:0] x_count_latch;
   logic [word_w-1:0] y_count;
   hop_e              hop;
   blit_op_e          op;
   logic [skew_w-1:0] skew;
   logic              busy;

   // sequencer events
   logic start_ack;
   logic src_step;
   logic dst_step;
   logic row_end;

   modport regs (
      output ht_line, src_x_inc, src_y_inc, src_addr, dst_x_inc, dst_y_inc, dst_addr,
      output endmask1, endmask2, endmask3, x_count, x_count_latch, y_count,
      output hop, op, skew, busy,
      input  start_ack, src_step, dst_step, row_end
   );

   modport seq (
      input  src_addr, dst_addr, endmask1, endmask2, endmask3,
      input  x_count, x_count_latch, y_count, hop, op, busy,
      output start_ack, src_step, dst_step, row_end
   );

   modport dp (input ht_line, src_x_inc, endmask1, endmask2, endmask3, hop, op, skew);
endinterface

// per-word strobes between sequencer and datapath
interface blit_step_if;
   import blit_pkg::*;

   logic              src_load;
   logic              dst_load;
   logic              clear;
   logic              first;
   logic              last;
   logic [word_w-1:0] rd_data;
   logic [word_w-1:0] wr_data;

   modport seq (output src_load, dst_load, clear, first, last, rd_data);
   modport dp  (input src_load, dst_load, clear, first, last, rd_data, output wr_data);
endinterface

/* blit_pkg.sv */
package blit_pkg;

   // ------------------------------
   // widths
   // ------------------------------
   localparam int word_w     = 16;
   localparam int adr_w      = 23;
   localparam int reg_addr_w = 5;
   localparam int ht_lines   = 16;
   localparam int line_w     = $clog2(ht_lines);
   localparam int skew_w     = 4;

   // ------------------------------
   // register map, word addresses
   // ------------------------------
   // halftone ram occupies 0x00 to 0x0f
   localparam logic [reg_addr_w-1:0] reg_ht_base   = 5'h00;
   localparam logic [reg_addr_w-1:0] reg_src_x_inc = 5'h10;
   localparam logic [reg_addr_w-1:0] reg_src_y_inc = 5'h11;
   localparam logic [reg_addr_w-1:0] reg_src_hi    = 5'h12;
   localparam logic [reg_addr_w-1:0] reg_src_lo    = 5'h13;
   localparam logic [reg_addr_w-1:0] reg_endmask1  = 5'h14;
   localparam logic [reg_addr_w-1:0] reg_endmask2  = 5'h15;
   localparam logic [reg_addr_w-1:0] reg_endmask3  = 5'h16;
   localparam logic [reg_addr_w-1:0] reg_dst_x_inc = 5'h17;
   localparam logic [reg_addr_w-1:0] reg_dst_y_inc = 5'h18;
   localparam logic [reg_addr_w-1:0] reg_dst_hi    = 5'h19;
   localparam logic [reg_addr_w-1:0] reg_dst_lo    = 5'h1a;
   localparam logic [reg_addr_w-1:0] reg_x_count   = 5'h1b;
   localparam logic [reg_addr_w-1:0] reg_y_count   = 5'h1c;
   localparam logic [reg_addr_w-1:0] reg_op        = 5'h1d;
   localparam logic [reg_addr_w-1:0] reg_ctrl      = 5'h1e;

   localparam int ctrl_busy_bit = 15;

   // logic ops, src against dst
   typedef enum logic [3:0] {
      op_zero, op_and, op_and_not_dst, op_src,
      op_not_src_and_dst, op_dst, op_xor, op_or,
      op_nor, op_xnor, op_not_dst, op_src_or_not_dst,
      op_not_src, op_not_src_or_dst, op_nand, op_one
   } blit_op_e;

   typedef enum logic [1:0] {hop_ones, hop_halftone, hop_source, hop_and} hop_e;

   typedef enum logic [1:0] {st_idle, st_src_read, st_dst_read, st_dst_write} seq_state_e;

   // ops with no src term
   function automatic logic op_uses_src(input blit_op_e op);
      return !(op inside {op_zero, op_dst, op_not_dst, op_one});
   endfunction

   // ops with no dst term
   function automatic logic op_uses_dst(input blit_op_e op);
      return !(op inside {op_zero, op_src, op_not_src, op_one});
   endfunction

   function automatic logic hop_uses_src(input hop_e hop);
      return hop inside {hop_source, hop_and};
   endfunction

endpackage
